// ==== cdi_nvram_pkg.sv ====
package cdi_nvram_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    // Full CD-i NvRAM is 8 KB
    parameter int NVRAM_BYTES_DEFAULT = 8192;

    parameter int HOST_WORD_W = 16;
    parameter int NVRAM_BYTE_W = 8;

    // ==================================================
    // Transfer FSM
    // ==================================================

    typedef enum logic [3:0] {
        NVRAM_IDLE,
        NVRAM_WAIT_FOR_ACK,
        NVRAM_BACKUP0,
        NVRAM_BACKUP1,
        NVRAM_BACKUP2,
        NVRAM_BACKUP3,
        NVRAM_RESTORE0,
        NVRAM_RESTORE1,
        NVRAM_RESTORE2
    } nvram_state_e;

    // ==================================================
    // Host word
    // ==================================================

    // Host words are little endian, lo is the byte at the even address
    typedef union packed {
        logic [HOST_WORD_W-1:0] word;
        struct packed {
            logic [NVRAM_BYTE_W-1:0] hi;
            logic [NVRAM_BYTE_W-1:0] lo;
        } bytes;
    } host_word_u;

endpackage

// ==== nvram_host_sequencer.sv ====
`timescale 1ns/1ns

module nvram_host_sequencer
    import cdi_nvram_pkg::*;
#(
    parameter int NVRAM_BYTES = NVRAM_BYTES_DEFAULT,
    localparam int ADDR_W = $clog2(NVRAM_BYTES)
) (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  logic                    img_mounted,
    input  logic                    img_size_nonzero,
    input  logic                    osd_status,
    input  logic                    hps_ack,
    input  logic                    sd_buff_wr,
    input  logic [HOST_WORD_W-1:0]  sd_buff_dout,
    input  logic                    cpu_changed,
    input  logic                    word_taken,
    output logic                    hps_rd,
    output logic                    hps_wr,
    output logic                    backup_pending,
    output logic                    cpu_access_allowed,
    output logic [ADDR_W-1:0]       st_addr,
    output logic [NVRAM_BYTE_W-1:0] st_wdata,
    output logic                    st_we,
    output logic                    capture_lo,
    output logic                    capture_hi
);

    nvram_state_e state;
    host_word_u   restore_word;
    logic         img_is_mounted;
    logic         osd_status_q;
    logic         img_mount;
    logic         osd_opened;

    // Mount pulse only counts for a non-empty image
    assign img_mount  = img_mounted && img_size_nonzero;
    assign osd_opened = osd_status && !osd_status_q;

    // Address bit 0 picks which half of the host word goes to the store
    assign st_wdata = st_addr[0] ? restore_word.bytes.hi : restore_word.bytes.lo;

    // Store data arrives one cycle after the address, the packer latches it here
    assign capture_lo = (state == NVRAM_BACKUP1);
    assign capture_hi = (state == NVRAM_BACKUP2);

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            img_is_mounted <= 1'b0;
            osd_status_q   <= 1'b0;
        end else begin
            osd_status_q <= osd_status;
            if (img_mounted) begin
                img_is_mounted <= img_size_nonzero;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == NVRAM_RESTORE0 && sd_buff_wr) begin
            restore_word.word <= sd_buff_dout;
        end
    end

    // ==================================================
    // Transfer FSM
    // ==================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state              <= NVRAM_IDLE;
            hps_rd             <= 1'b0;
            hps_wr             <= 1'b0;
            backup_pending     <= 1'b0;
            cpu_access_allowed <= 1'b1;
            st_addr            <= '0;
            st_we              <= 1'b0;
        end else begin
            st_we <= 1'b0;

            if (cpu_changed && img_is_mounted) begin
                backup_pending <= 1'b1;
            end

            // Request is done once the host answers
            if (hps_ack) begin
                hps_rd <= 1'b0;
                hps_wr <= 1'b0;
            end

            case (state)
                NVRAM_IDLE: begin
                    cpu_access_allowed <= 1'b1;
                    st_addr            <= '0;
                    if (img_mount) begin
                        hps_rd             <= 1'b1;
                        cpu_access_allowed <= 1'b0;
                        state              <= NVRAM_WAIT_FOR_ACK;
                    end else if (backup_pending && osd_opened) begin
                        // Cleared now so edits made during the backup trigger another one
                        backup_pending     <= 1'b0;
                        hps_wr             <= 1'b1;
                        cpu_access_allowed <= 1'b0;
                        state              <= NVRAM_WAIT_FOR_ACK;
                    end
                end
                NVRAM_WAIT_FOR_ACK: begin
                    if (hps_ack && hps_rd) begin
                        state <= NVRAM_RESTORE0;
                    end
                    if (hps_ack && hps_wr) begin
                        state <= NVRAM_BACKUP0;
                    end
                end
                NVRAM_BACKUP0: begin
                    st_addr <= st_addr + 1'b1;
                    state   <= NVRAM_BACKUP1;
                end
                NVRAM_BACKUP1: begin
                    st_addr <= st_addr + 1'b1;
                    state   <= hps_ack ? NVRAM_BACKUP2 : NVRAM_IDLE;
                end
                NVRAM_BACKUP2: begin
                    state <= hps_ack ? NVRAM_BACKUP3 : NVRAM_IDLE;
                end
                NVRAM_BACKUP3: begin
                    // Word is on hps_din, wait for the host to take it
                    if (!hps_ack) begin
                        state <= NVRAM_IDLE;
                    end else if (word_taken) begin
                        st_addr <= st_addr + 1'b1;
                        state   <= NVRAM_BACKUP1;
                    end
                end
                NVRAM_RESTORE0: begin
                    if (sd_buff_wr) begin
                        st_we <= 1'b1;
                        state <= NVRAM_RESTORE1;
                    end else if (!hps_ack) begin
                        cpu_access_allowed <= 1'b1;
                        state              <= NVRAM_IDLE;
                    end
                end
                NVRAM_RESTORE1: begin
                    // Low byte written this cycle, high byte next
                    st_we   <= 1'b1;
                    st_addr <= st_addr + 1'b1;
                    state   <= NVRAM_RESTORE2;
                end
                NVRAM_RESTORE2: begin
                    st_addr <= st_addr + 1'b1;
                    if (hps_ack) begin
                        state <= NVRAM_RESTORE0;
                    end else begin
                        cpu_access_allowed <= 1'b1;
                        state              <= NVRAM_IDLE;
                    end
                end
                default: begin
                    state <= NVRAM_IDLE;
                end
            endcase
        end
    end

    a_rd_wr_exclusive: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        !(hps_rd && hps_wr)
    );

endmodule

// ==== nvram_store.sv ====
`timescale 1ns/1ns

module nvram_store
    import cdi_nvram_pkg::*;
#(
    parameter int NVRAM_BYTES = NVRAM_BYTES_DEFAULT,
    localparam int ADDR_W = $clog2(NVRAM_BYTES)
) (
    input  logic                    clk_sys,
    input  logic [ADDR_W-1:0]       cpu_addr,
    input  logic [NVRAM_BYTE_W-1:0] cpu_wdata,
    input  logic                    cpu_we,
    input  logic                    cpu_access_allowed,
    input  logic [ADDR_W-1:0]       st_addr,
    input  logic [NVRAM_BYTE_W-1:0] st_wdata,
    input  logic                    st_we,
    output logic [NVRAM_BYTE_W-1:0] cpu_rdata,
    output logic [NVRAM_BYTE_W-1:0] st_rdata,
    output logic                    cpu_changed
);

    logic [NVRAM_BYTE_W-1:0] mem [NVRAM_BYTES];
    logic                    cpu_write_ok;

    // CPU is locked out while the host owns the store
    assign cpu_write_ok = cpu_we && cpu_access_allowed;

    always_ff @(posedge clk_sys) begin
        if (st_we) begin
            mem[st_addr] <= st_wdata;
        end else if (cpu_write_ok) begin
            mem[cpu_addr] <= cpu_wdata;
        end
    end

    // Registered reads on both ports
    always_ff @(posedge clk_sys) begin
        cpu_rdata <= mem[cpu_addr];
        st_rdata  <= mem[st_addr];
    end

    always_ff @(posedge clk_sys) begin
        cpu_changed <= cpu_write_ok;
    end

    // Sequencer only writes while it holds the CPU off
    a_no_write_conflict: assert property (
        @(posedge clk_sys)
        st_we |-> !cpu_access_allowed
    );

endmodule

// ==== nvram_backup_packer.sv ====
`timescale 1ns/1ns

module nvram_backup_packer
    import cdi_nvram_pkg::*;
#(
    parameter int NVRAM_BYTES = NVRAM_BYTES_DEFAULT
) (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  logic [NVRAM_BYTE_W-1:0] st_rdata,
    input  logic                    capture_lo,
    input  logic                    capture_hi,
    input  logic                    sd_buff_addr_lsb,
    output logic [HOST_WORD_W-1:0]  hps_din,
    output logic                    word_taken
);

    host_word_u hps_word;
    logic       addr_lsb_q;

    // Two bytes per host word
    if (NVRAM_BYTES % 2 != 0) begin : g_odd_size
        $error("NvRAM size must be a whole number of host words");
    end

    always_ff @(posedge clk_sys) begin
        if (capture_lo) begin
            hps_word.bytes.lo <= st_rdata;
        end
        if (capture_hi) begin
            hps_word.bytes.hi <= st_rdata;
        end
    end

    assign hps_din = hps_word.word;

    // Host moves on to the next word by flipping the buffer address LSB
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            addr_lsb_q <= 1'b0;
        end else begin
            addr_lsb_q <= sd_buff_addr_lsb;
        end
    end

    assign word_taken = sd_buff_addr_lsb != addr_lsb_q;

    a_capture_exclusive: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        !(capture_lo && capture_hi)
    );

endmodule

// ==== cdi_nvram_top.sv ====
`timescale 1ns/1ns

module cdi_nvram_top
    import cdi_nvram_pkg::*;
#(
    parameter int NVRAM_BYTES = NVRAM_BYTES_DEFAULT,
    localparam int ADDR_W = $clog2(NVRAM_BYTES)
) (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,

    // Host side
    input  logic                    img_mounted,
    input  logic                    img_size_nonzero,
    input  logic                    osd_status,
    input  logic                    hps_ack,
    input  logic                    sd_buff_wr,
    input  logic [HOST_WORD_W-1:0]  sd_buff_dout,
    input  logic                    sd_buff_addr_lsb,
    output logic                    hps_rd,
    output logic                    hps_wr,
    output logic [HOST_WORD_W-1:0]  hps_din,

    // CPU side
    input  logic [ADDR_W-1:0]       cpu_addr,
    input  logic [NVRAM_BYTE_W-1:0] cpu_wdata,
    input  logic                    cpu_we,
    output logic [NVRAM_BYTE_W-1:0] cpu_rdata,
    output logic                    cpu_access_allowed,

    // Lit while a backup is pending
    output logic                    led_user
);

    logic [ADDR_W-1:0]       st_addr;
    logic [NVRAM_BYTE_W-1:0] st_wdata;
    logic                    st_we;
    logic [NVRAM_BYTE_W-1:0] st_rdata;
    logic                    capture_lo;
    logic                    capture_hi;
    logic                    word_taken;
    logic                    cpu_changed;

    nvram_host_sequencer #(
        .NVRAM_BYTES(NVRAM_BYTES)
    ) u_sequencer (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .img_mounted       (img_mounted),
        .img_size_nonzero  (img_size_nonzero),
        .osd_status        (osd_status),
        .hps_ack           (hps_ack),
        .sd_buff_wr        (sd_buff_wr),
        .sd_buff_dout      (sd_buff_dout),
        .cpu_changed       (cpu_changed),
        .word_taken        (word_taken),
        .hps_rd            (hps_rd),
        .hps_wr            (hps_wr),
        .backup_pending    (led_user),
        .cpu_access_allowed(cpu_access_allowed),
        .st_addr           (st_addr),
        .st_wdata          (st_wdata),
        .st_we             (st_we),
        .capture_lo        (capture_lo),
        .capture_hi        (capture_hi)
    );

    nvram_store #(
        .NVRAM_BYTES(NVRAM_BYTES)
    ) u_store (
        .clk_sys           (clk_sys),
        .cpu_addr          (cpu_addr),
        .cpu_wdata         (cpu_wdata),
        .cpu_we            (cpu_we),
        .cpu_access_allowed(cpu_access_allowed),
        .st_addr           (st_addr),
        .st_wdata          (st_wdata),
        .st_we             (st_we),
        .cpu_rdata         (cpu_rdata),
        .st_rdata          (st_rdata),
        .cpu_changed       (cpu_changed)
    );

    nvram_backup_packer #(
        .NVRAM_BYTES(NVRAM_BYTES)
    ) u_packer (
        .clk_sys         (clk_sys),
        .cditop_reset    (cditop_reset),
        .st_rdata        (st_rdata),
        .capture_lo      (capture_lo),
        .capture_hi      (capture_hi),
        .sd_buff_addr_lsb(sd_buff_addr_lsb),
        .hps_din         (hps_din),
        .word_taken      (word_taken)
    );

endmodule

// ==== tb_cdi_nvram_top.sv ====
`timescale 1ns/1ns

module tb_cdi_nvram_top;

    localparam int NVRAM_BYTES    = 64;
    localparam int ADDR_W         = $clog2(NVRAM_BYTES);
    localparam int WORDS          = NVRAM_BYTES / 2;
    localparam int EDITS          = 4;
    localparam int EDIT_BASE      = WORDS;
    localparam int EXP_BASE       = WORDS + EDITS;
    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = 200 * 64 + 2000;

    logic              clk_sys;
    logic              cditop_reset;
    logic              img_mounted;
    logic              img_size_nonzero;
    logic              osd_status;
    logic              hps_ack;
    logic              sd_buff_wr;
    logic [15:0]       sd_buff_dout;
    logic              sd_buff_addr_lsb;
    logic              hps_rd;
    logic              hps_wr;
    logic [15:0]       hps_din;
    logic [ADDR_W-1:0] cpu_addr;
    logic [7:0]        cpu_wdata;
    logic              cpu_we;
    logic [7:0]        cpu_rdata;
    logic              cpu_access_allowed;
    logic              led_user;

    // Restore words, CPU edits, expected backup words
    logic [15:0] testdata [EXP_BASE + WORDS];
    logic [15:0] backup_words [WORDS];
    logic [31:0] rng_state;

    cdi_nvram_top #(
        .NVRAM_BYTES(NVRAM_BYTES)
    ) uut (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .img_mounted       (img_mounted),
        .img_size_nonzero  (img_size_nonzero),
        .osd_status        (osd_status),
        .hps_ack           (hps_ack),
        .sd_buff_wr        (sd_buff_wr),
        .sd_buff_dout      (sd_buff_dout),
        .sd_buff_addr_lsb  (sd_buff_addr_lsb),
        .hps_rd            (hps_rd),
        .hps_wr            (hps_wr),
        .hps_din           (hps_din),
        .cpu_addr          (cpu_addr),
        .cpu_wdata         (cpu_wdata),
        .cpu_we            (cpu_we),
        .cpu_rdata         (cpu_rdata),
        .cpu_access_allowed(cpu_access_allowed),
        .led_user          (led_user)
    );

    initial clk_sys = 1'b0;
    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Extra idle cycles of 0 to 3 between host words
    task automatic random_gap();
        rng_state = lcg_step(rng_state);
        repeat (rng_state[17:16]) @(negedge clk_sys);
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    // hps_ack changes on the falling edge, so look at it on the rising edge
    task automatic wait_ack(input logic level);
        do begin
            @(posedge clk_sys);
        end while (hps_ack !== level);
        @(negedge clk_sys);
    endtask

    task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_we    = 1'b1;
        @(negedge clk_sys);
        cpu_we    = 1'b0;
    endtask

    task automatic cpu_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
        cpu_addr = addr;
        @(negedge clk_sys);
        data = cpu_rdata;
    endtask

    // ==================================================
    // Host model
    // ==================================================

    initial begin : host_model
        int n;
        forever begin
            @(negedge clk_sys);
            if (hps_rd) begin
                hps_ack = 1'b1;
                for (n = 0; n < WORDS; n++) begin
                    // Sequencer takes a word every 4 cycles at most
                    idle(3);
                    random_gap();
                    sd_buff_dout = testdata[n];
                    sd_buff_wr   = 1'b1;
                    @(negedge clk_sys);
                    sd_buff_wr   = 1'b0;
                end
                idle(4);
                hps_ack = 1'b0;
            end else if (hps_wr) begin
                hps_ack = 1'b1;
                for (n = 0; n < WORDS; n++) begin
                    idle(8);
                    random_gap();
                    backup_words[n]  = hps_din;
                    sd_buff_addr_lsb = ~sd_buff_addr_lsb;
                end
                idle(4);
                hps_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
        $display("Timeout: transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1);
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin : stimulus
        logic [7:0]  rd_byte;
        logic [7:0]  exp_byte;
        logic [15:0] edit;
        logic        wr_seen;
        int          a;
        int          k;

        cditop_reset     = 1'b1;
        img_mounted      = 1'b0;
        img_size_nonzero = 1'b0;
        osd_status       = 1'b0;
        hps_ack          = 1'b0;
        sd_buff_wr       = 1'b0;
        sd_buff_dout     = '0;
        sd_buff_addr_lsb = 1'b0;
        cpu_addr         = '0;
        cpu_wdata        = '0;
        cpu_we           = 1'b0;
        rng_state        = 32'd28339;
        $readmemh("nvram_testdata.hex", testdata);

        // Reset held over three rising edges
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        cditop_reset = 1'b0;
        @(negedge clk_sys);
        check("reset led_user", 16'd0, led_user);
        check("reset cpu_access_allowed", 16'd1, cpu_access_allowed);

        // Restore from a non-empty image
        img_mounted      = 1'b1;
        img_size_nonzero = 1'b1;
        @(negedge clk_sys);
        img_mounted      = 1'b0;
        wait_ack(1'b1);
        check("restore request cleared", 16'd0, hps_rd);
        check("restore lockout", 16'd0, cpu_access_allowed);
        wait_ack(1'b0);
        idle(1);
        check("restore access", 16'd1, cpu_access_allowed);
        for (a = 0; a < NVRAM_BYTES; a++) begin
            cpu_read(a[ADDR_W-1:0], rd_byte);
            exp_byte = a[0] ? testdata[a / 2][15:8] : testdata[a / 2][7:0];
            check($sformatf("restore byte %0d", a), {8'h00, exp_byte}, {8'h00, rd_byte});
        end
        check("restore led_user", 16'd0, led_user);

        for (k = 0; k < EDITS; k++) begin
            edit = testdata[EDIT_BASE + k];
            cpu_write(edit[8 +: ADDR_W], edit[7:0]);
        end
        idle(2);
        check("edit led_user", 16'd1, led_user);

        // Backup on OSD open with a CPU write tried while the host owns the store
        osd_status = 1'b1;
        wr_seen    = 1'b0;
        repeat (4) begin
            @(negedge clk_sys);
            wr_seen = wr_seen | hps_wr;
        end
        check("backup request", 16'd1, wr_seen);
        wait_ack(1'b1);
        check("backup request cleared", 16'd0, hps_wr);
        check("backup lockout", 16'd0, cpu_access_allowed);
        cpu_write('0, ~testdata[EXP_BASE][7:0]);
        wait_ack(1'b0);
        osd_status = 1'b0;
        idle(1);
        check("backup access", 16'd1, cpu_access_allowed);
        check("backup led_user", 16'd0, led_user);
        for (k = 0; k < WORDS; k++) begin
            check($sformatf("backup word %0d", k), testdata[EXP_BASE + k], backup_words[k]);
        end
        cpu_read('0, rd_byte);
        check("lockout write", {8'h00, testdata[EXP_BASE][7:0]}, {8'h00, rd_byte});

        cpu_write(6'd5, 8'h5c);
        idle(2);
        check("pending before reset", 16'd1, led_user);
        cditop_reset = 1'b1;
        @(negedge clk_sys);
        cditop_reset = 1'b0;
        @(negedge clk_sys);
        check("reset clears led_user", 16'd0, led_user);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== nvram_testdata.hex ====
// One 16-bit hex word per entry, eight entries per line
// Restore image words, then CPU edits as {addr, byte}, then expected backup words

// Restore image, word n holds byte 2n+1 in hi and byte 2n in lo
A4A5 A6A7 A0A1 A2A3 ACAD AEAF A8A9 AAAB
B4B5 B6B7 B0B1 B2B3 BCBD BEBF B8B9 BABB
8485 8687 8081 8283 8C8D 8E8F 8889 8A8B
9495 9697 9091 9293 9C9D 9E9F 9899 9A9B

// CPU edits
0311 1022 2B33 3E44

// Expected backup words
A4A5 11A7 A0A1 A2A3 ACAD AEAF A8A9 AAAB
B422 B6B7 B0B1 B2B3 BCBD BEBF B8B9 BABB
8485 8687 8081 8283 8C8D 338F 8889 8A8B
9495 9697 9091 9293 9C9D 9E9F 9899 9A44

// ==== cdi_nvram_top.f ====
cdi_nvram_pkg.sv
nvram_host_sequencer.sv
nvram_store.sv
nvram_backup_packer.sv
cdi_nvram_top.sv
tb_cdi_nvram_top.sv

// ==== Bender.yml ====
package:
  name: cdi_nvram

sources:
  - cdi_nvram_pkg.sv
  - nvram_host_sequencer.sv
  - nvram_store.sv
  - nvram_backup_packer.sv
  - cdi_nvram_top.sv
  - target: test
    files:
      - tb_cdi_nvram_top.sv
